// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= flappyTopTb
FILELIST ?= flappyTop.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flappyTop.f ====
hdl/flapPkg.sv
hdl/vgaTiming.sv
hdl/birdMotion.sv
hdl/pipeField.sv
hdl/sceneCompositor.sv
hdl/scoreDisplay.sv
hdl/flappyTop.sv
tests/flappyTop_props.sv
tests/flappyTopTb.sv

// ==== hdl/birdMotion.sv ====
`timescale 1ns/1ps

module birdMotion
	import flapPkg::*;
#(
	parameter int V_ACTIVE = DEF_V_ACTIVE,
	parameter int BIRD_SIZE = DEF_BIRD_SIZE,
	parameter int FLAP_RISE = DEF_FLAP_RISE,
	parameter int GRAVITY_STEP = DEF_GRAVITY_STEP
) (
	input logic clk25M,
	input logic rst,
	input logic btnUp,
	input logic framePulse,
	input gamePhase_t phase,
	output coord_t birdY,
	output logic hitFloor,
	output logic startFlap
);

	localparam coord_t START_Y = coord_t'(V_ACTIVE / 2 - BIRD_SIZE / 2);
	localparam coord_t FLOOR_Y = coord_t'(V_ACTIVE - BIRD_SIZE);
	localparam coord_t RISE = coord_t'(FLAP_RISE);
	localparam coord_t FALL = coord_t'(GRAVITY_STEP);

	logic [1:0] btnSync;
	logic btnLast;
	logic btnFell;
	logic flapPending;

	// button idles high
	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			btnSync <= 2'b11;
			btnLast <= 1'b1;
		end else begin
			btnSync <= {btnSync[0], btnUp};
			btnLast <= btnSync[1];
		end
	end

	assign btnFell = btnLast & ~btnSync[1];

	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			flapPending <= 1'b0;
			birdY <= START_Y;
			hitFloor <= 1'b0;
			startFlap <= 1'b0;
		end else begin
			startFlap <= btnFell && (phase == phIdle);
			if (framePulse) begin
				// a press on the frame edge counts for the next frame
				flapPending <= btnFell;
				if (phase != phCrashed) begin
					if (flapPending) begin
						birdY <= (birdY > RISE) ? birdY - RISE : '0;
					end else if (phase == phFlying) begin
						if (birdY + FALL >= FLOOR_Y) begin
							birdY <= FLOOR_Y;
							hitFloor <= 1'b1;
						end else begin
							birdY <= birdY + FALL;
						end
					end
				end
			end else if (btnFell) begin
				flapPending <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/flapPkg.sv ====
package flapPkg;

	// raster coordinate and colour
	typedef logic [9:0] coord_t;
	typedef logic [11:0] rgb_t;

	typedef enum logic [1:0] {
		phIdle,
		phFlying,
		phCrashed
	} gamePhase_t;

	localparam rgb_t SKY_COLOR = 12'h8CE;
	localparam rgb_t PIPE_COLOR = 12'h3A2;
	localparam rgb_t BIRD_COLOR = 12'hFF0;
	localparam rgb_t CRASH_COLOR = 12'hF00;

	// 640x480 blanking intervals
	localparam logic [9:0] H_FRONT = 10'd16;
	localparam logic [9:0] H_SYNC = 10'd96;
	localparam logic [9:0] H_BACK = 10'd48;
	localparam logic [9:0] V_FRONT = 10'd10;
	localparam logic [9:0] V_SYNC = 10'd2;
	localparam logic [9:0] V_BACK = 10'd33;

	// pipe gets one step faster at each of these
	localparam logic [2:0][7:0] SPEEDUP_SCORES = {8'd30, 8'd15, 8'd5};

	// default geometry
	localparam int DEF_H_ACTIVE = 640;
	localparam int DEF_V_ACTIVE = 480;
	localparam int DEF_BIRD_X = 303;
	localparam int DEF_BIRD_SIZE = 32;
	localparam int DEF_FLAP_RISE = 40;
	localparam int DEF_GRAVITY_STEP = 5;
	localparam int DEF_PIPE_WIDTH = 64;
	localparam int DEF_GAP_HEIGHT = 150;
	localparam int DEF_PIPE_STEP = 10;
	localparam int DEF_FLASH_FRAMES = 30;

endpackage

// ==== hdl/flappyTop.sv ====
`timescale 1ns/1ps

module flappyTop
	import flapPkg::*;
#(
	parameter int H_ACTIVE = DEF_H_ACTIVE,
	parameter int V_ACTIVE = DEF_V_ACTIVE,
	parameter int BIRD_X = DEF_BIRD_X,
	parameter int BIRD_SIZE = DEF_BIRD_SIZE,
	parameter int FLAP_RISE = DEF_FLAP_RISE,
	parameter int GRAVITY_STEP = DEF_GRAVITY_STEP,
	parameter int PIPE_WIDTH = DEF_PIPE_WIDTH,
	parameter int GAP_HEIGHT = DEF_GAP_HEIGHT,
	parameter int PIPE_STEP = DEF_PIPE_STEP,
	parameter int FLASH_FRAMES = DEF_FLASH_FRAMES
) (
	input logic clk25M,
	input logic rst,
	input logic btnUp,
	output logic hsync,
	output logic vsync,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue,
	output logic [6:0] seg0,
	output logic [6:0] seg1
);

	coord_t pixelX;
	coord_t pixelY;
	coord_t birdY;
	coord_t pipeX;
	coord_t gapTop;
	logic active;
	logic framePulse;
	logic hitFloor;
	logic startFlap;
	logic [7:0] score;
	gamePhase_t phase;

	vgaTiming #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) timing (
		.clk25M(clk25M), .rst(rst), .pixelX(pixelX), .pixelY(pixelY),
		.active(active), .hsync(hsync), .vsync(vsync), .framePulse(framePulse)
	);

	birdMotion #(
		.V_ACTIVE(V_ACTIVE), .BIRD_SIZE(BIRD_SIZE),
		.FLAP_RISE(FLAP_RISE), .GRAVITY_STEP(GRAVITY_STEP)
	) bird (
		.clk25M(clk25M), .rst(rst), .btnUp(btnUp), .framePulse(framePulse),
		.phase(phase), .birdY(birdY), .hitFloor(hitFloor), .startFlap(startFlap)
	);

	pipeField #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BIRD_X(BIRD_X),
		.PIPE_WIDTH(PIPE_WIDTH), .GAP_HEIGHT(GAP_HEIGHT), .PIPE_STEP(PIPE_STEP)
	) pipes (
		.clk25M(clk25M), .rst(rst), .framePulse(framePulse), .phase(phase),
		.pipeX(pipeX), .gapTop(gapTop), .score(score)
	);

	sceneCompositor #(
		.BIRD_X(BIRD_X), .BIRD_SIZE(BIRD_SIZE),
		.PIPE_WIDTH(PIPE_WIDTH), .GAP_HEIGHT(GAP_HEIGHT)
	) scene (
		.clk25M(clk25M), .rst(rst), .pixelX(pixelX), .pixelY(pixelY),
		.active(active), .birdY(birdY), .pipeX(pipeX), .gapTop(gapTop),
		.hitFloor(hitFloor), .startFlap(startFlap), .phase(phase),
		.red(red), .green(green), .blue(blue)
	);

	scoreDisplay #(.FLASH_FRAMES(FLASH_FRAMES)) display (
		.clk25M(clk25M), .rst(rst), .score(score), .phase(phase),
		.framePulse(framePulse), .seg0(seg0), .seg1(seg1)
	);

endmodule

// ==== hdl/pipeField.sv ====
`timescale 1ns/1ps

module pipeField
	import flapPkg::*;
#(
	parameter int H_ACTIVE = DEF_H_ACTIVE,
	parameter int V_ACTIVE = DEF_V_ACTIVE,
	parameter int BIRD_X = DEF_BIRD_X,
	parameter int PIPE_WIDTH = DEF_PIPE_WIDTH,
	parameter int GAP_HEIGHT = DEF_GAP_HEIGHT,
	parameter int PIPE_STEP = DEF_PIPE_STEP
) (
	input logic clk25M,
	input logic rst,
	input logic framePulse,
	input gamePhase_t phase,
	output coord_t pipeX,
	output coord_t gapTop,
	output logic [7:0] score
);

	localparam coord_t PIPE_START = coord_t'(H_ACTIVE);
	localparam coord_t BX = coord_t'(BIRD_X);
	localparam coord_t PW = coord_t'(PIPE_WIDTH);
	// eight gap slots over the free height
	localparam coord_t GAP_UNIT = coord_t'((V_ACTIVE - GAP_HEIGHT) / 8);
	localparam coord_t GAP_START = coord_t'(4 * ((V_ACTIVE - GAP_HEIGHT) / 8));

	logic [2:0] lfsr;
	logic [2:0] lfsrNext;
	coord_t step;
	logic passed;
	logic [2:0] speedDone;

	// x^3 + x^2 + 1, period 7
	assign lfsrNext = {lfsr[1:0], lfsr[2] ^ lfsr[1]};

	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			pipeX <= PIPE_START;
			gapTop <= GAP_START;
			lfsr <= 3'b100;
			score <= '0;
			passed <= 1'b0;
		end else if (framePulse && phase == phFlying) begin
			if (!passed && (pipeX + PW < BX)) begin
				score <= score + 1'b1;
				passed <= 1'b1;
			end
			if (pipeX <= step) begin
				pipeX <= PIPE_START;
				lfsr <= lfsrNext;
				gapTop <= lfsrNext * GAP_UNIT;
				passed <= 1'b0;
			end else begin
				pipeX <= pipeX - step;
			end
		end
	end

	// score moves by one per frame, so at most one level per cycle
	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			step <= coord_t'(PIPE_STEP);
			speedDone <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (!speedDone[i] && score >= SPEEDUP_SCORES[i]) begin
					speedDone[i] <= 1'b1;
					step <= step + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/sceneCompositor.sv ====
`timescale 1ns/1ps

module sceneCompositor
	import flapPkg::*;
#(
	parameter int BIRD_X = DEF_BIRD_X,
	parameter int BIRD_SIZE = DEF_BIRD_SIZE,
	parameter int PIPE_WIDTH = DEF_PIPE_WIDTH,
	parameter int GAP_HEIGHT = DEF_GAP_HEIGHT
) (
	input logic clk25M,
	input logic rst,
	input coord_t pixelX,
	input coord_t pixelY,
	input logic active,
	input coord_t birdY,
	input coord_t pipeX,
	input coord_t gapTop,
	input logic hitFloor,
	input logic startFlap,
	output gamePhase_t phase,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue
);

	localparam coord_t BX = coord_t'(BIRD_X);
	localparam coord_t BSZ = coord_t'(BIRD_SIZE);
	localparam coord_t PW = coord_t'(PIPE_WIDTH);
	localparam coord_t GAP = coord_t'(GAP_HEIGHT);

	logic birdPix;
	logic wallPix;
	rgb_t pixColor;

	assign birdPix = (pixelX >= BX) && (pixelX < BX + BSZ) &&
		(pixelY >= birdY) && (pixelY < birdY + BSZ);
	assign wallPix = (pixelX >= pipeX) && (pixelX < pipeX + PW) &&
		((pixelY < gapTop) || (pixelY >= gapTop + GAP));

	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			phase <= phIdle;
		end else begin
			case (phase)
				phIdle: begin
					if (startFlap) phase <= phFlying;
				end
				phFlying: begin
					// bird drawn on top of a wall pixel
					if (hitFloor || (active && birdPix && wallPix)) phase <= phCrashed;
				end
				default: phase <= phCrashed;
			endcase
		end
	end

	always_comb begin
		if (phase == phCrashed) begin
			pixColor = CRASH_COLOR;
		end else if (birdPix) begin
			pixColor = BIRD_COLOR;
		end else if (wallPix && phase == phFlying) begin
			pixColor = PIPE_COLOR;
		end else begin
			pixColor = SKY_COLOR;
		end
	end

	// one cycle behind the counters
	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			{red, green, blue} <= '0;
		end else begin
			{red, green, blue} <= active ? pixColor : '0;
		end
	end

endmodule

// ==== hdl/scoreDisplay.sv ====
`timescale 1ns/1ps

module scoreDisplay
	import flapPkg::*;
#(
	parameter int FLASH_FRAMES = DEF_FLASH_FRAMES
) (
	input logic clk25M,
	input logic rst,
	input logic [7:0] score,
	input gamePhase_t phase,
	input logic framePulse,
	output logic [6:0] seg0,
	output logic [6:0] seg1
);

	localparam int CNT_W = $clog2(FLASH_FRAMES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FLASH_FRAMES - 1);

	logic [7:0] scoreMod;
	logic [3:0] ones;
	logic [3:0] tens;
	logic [CNT_W-1:0] flashCnt;
	logic blankPhase;
	logic blankNow;

	// gfedcba, segment lit when low
	function automatic logic [6:0] segCode(input logic [3:0] digit);
		case (digit)
			4'd0: segCode = 7'b1000000;
			4'd1: segCode = 7'b1111001;
			4'd2: segCode = 7'b0100100;
			4'd3: segCode = 7'b0110000;
			4'd4: segCode = 7'b0011001;
			4'd5: segCode = 7'b0010010;
			4'd6: segCode = 7'b0000010;
			4'd7: segCode = 7'b1111000;
			4'd8: segCode = 7'b0000000;
			4'd9: segCode = 7'b0010000;
			default: segCode = 7'b1111111;
		endcase
	endfunction

	assign scoreMod = score % 8'd100;
	assign ones = 4'(scoreMod % 8'd10);
	assign tens = 4'(scoreMod / 8'd10);

	// blank half of the flash comes first
	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			flashCnt <= '0;
			blankPhase <= 1'b1;
		end else if (phase == phCrashed && framePulse) begin
			if (flashCnt == CNT_LAST) begin
				flashCnt <= '0;
				blankPhase <= ~blankPhase;
			end else begin
				flashCnt <= flashCnt + 1'b1;
			end
		end
	end

	assign blankNow = (phase == phCrashed) && blankPhase;
	assign seg0 = blankNow ? 7'h7F : segCode(ones);
	assign seg1 = blankNow ? 7'h7F : segCode(tens);

endmodule

// ==== hdl/vgaTiming.sv ====
`timescale 1ns/1ps

module vgaTiming
	import flapPkg::*;
#(
	parameter int H_ACTIVE = DEF_H_ACTIVE,
	parameter int V_ACTIVE = DEF_V_ACTIVE
) (
	input logic clk25M,
	input logic rst,
	output coord_t pixelX,
	output coord_t pixelY,
	output logic active,
	output logic hsync,
	output logic vsync,
	output logic framePulse
);

	localparam coord_t H_LAST = coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
	localparam coord_t V_LAST = coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
	localparam coord_t HS_START = coord_t'(H_ACTIVE + H_FRONT);
	localparam coord_t HS_END = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam coord_t VS_START = coord_t'(V_ACTIVE + V_FRONT);
	localparam coord_t VS_END = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
	localparam coord_t HA = coord_t'(H_ACTIVE);
	localparam coord_t VA = coord_t'(V_ACTIVE);

	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			pixelX <= '0;
			pixelY <= '0;
		end else if (pixelX == H_LAST) begin
			pixelX <= '0;
			pixelY <= (pixelY == V_LAST) ? '0 : pixelY + 1'b1;
		end else begin
			pixelX <= pixelX + 1'b1;
		end
	end

	// sync pulses are active low
	assign hsync = !(pixelX >= HS_START && pixelX < HS_END);
	assign vsync = !(pixelY >= VS_START && pixelY < VS_END);
	assign active = (pixelX < HA) && (pixelY < VA);
	assign framePulse = (pixelX == H_LAST) && (pixelY == V_LAST);

endmodule

// ==== tests/flappyTopTb.sv ====
`timescale 1ns/1ps

module flappyTopTb
	import flapPkg::*;
();

	localparam int H_ACTIVE = 128;
	localparam int V_ACTIVE = 96;
	localparam int BIRD_X = 40;
	localparam int BIRD_SIZE = 8;
	localparam int FLAP_RISE = 6;
	localparam int GRAVITY_STEP = 2;
	localparam int PIPE_WIDTH = 16;
	localparam int GAP_HEIGHT = 48;
	localparam int PIPE_STEP = 8;
	localparam int FLASH_FRAMES = 2;
	localparam int H_TOTAL = H_ACTIVE + 160;
	localparam int V_TOTAL = V_ACTIVE + 45;
	// wall crash comes near frame 29, flashing is done by frame 35
	localparam int TIMEOUT_CYCLES = 40 * H_TOTAL * V_TOTAL;

	logic clk25M;
	logic rst;
	logic btnUp;
	logic hsync;
	logic vsync;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;
	logic [6:0] seg0;
	logic [6:0] seg1;
	rgb_t rgb;

	int tx;
	int ty;
	int colD;
	logic activeD;
	logic boundary;
	int frameNo = 0;
	int modelY = V_ACTIVE / 2 - BIRD_SIZE / 2;
	int framesSincePress = 0;
	logic pressed = 1'b0;
	logic stopFlap = 1'b0;
	int curScore;
	logic valid;
	logic blank;
	int lastScore;
	logic lastValid;
	logic scored;
	logic birdSeen;
	logic crashSeen;
	int crashScore;
	logic blankLast;
	int runLen;
	logic runClean;
	int flashChecks;
	int cycles = 0;

	flappyTop #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BIRD_X(BIRD_X), .BIRD_SIZE(BIRD_SIZE),
		.FLAP_RISE(FLAP_RISE), .GRAVITY_STEP(GRAVITY_STEP), .PIPE_WIDTH(PIPE_WIDTH),
		.GAP_HEIGHT(GAP_HEIGHT), .PIPE_STEP(PIPE_STEP), .FLASH_FRAMES(FLASH_FRAMES)
	) UUT (
		.clk25M(clk25M), .rst(rst), .btnUp(btnUp), .hsync(hsync), .vsync(vsync),
		.red(red), .green(green), .blue(blue), .seg0(seg0), .seg1(seg1)
	);

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	// active-low gfedcba decode giving 15 for anything not a digit
	function automatic int digitOf(input logic [6:0] seg);
		case (seg)
			7'h40: digitOf = 0;
			7'h79: digitOf = 1;
			7'h24: digitOf = 2;
			7'h30: digitOf = 3;
			7'h19: digitOf = 4;
			7'h12: digitOf = 5;
			7'h02: digitOf = 6;
			7'h78: digitOf = 7;
			7'h00: digitOf = 8;
			7'h10: digitOf = 9;
			default: digitOf = 15;
		endcase
	endfunction

	assign rgb = {red, green, blue};
	assign boundary = (tx == 0) && (ty == 0);
	assign valid = (digitOf(seg0) < 10) && (digitOf(seg1) < 10);
	assign curScore = digitOf(seg1) * 10 + digitOf(seg0);
	assign blank = (seg0 == 7'h7F) && (seg1 == 7'h7F);

	initial begin
		clk25M = 1'b0;
		forever #20 clk25M = ~clk25M;
	end

	initial begin
		void'($urandom(32'h19074f68));
		rst = 1'b0;
		btnUp = 1'b1;
		repeat (8) @(posedge clk25M);
		rst <= 1'b1;
		wait (flashChecks >= 2);
		repeat (H_TOTAL) @(posedge clk25M);
		if (scored && crashSeen) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			failRun("bird crashed without passing a pipe");
		end
	end

	// own raster position with rgb one cycle behind it
	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			tx <= 0;
			ty <= 0;
			colD <= 0;
			activeD <= 1'b0;
		end else begin
			tx <= (tx == H_TOTAL - 1) ? 0 : tx + 1;
			if (tx == H_TOTAL - 1) ty <= (ty == V_TOTAL - 1) ? 0 : ty + 1;
			colD <= tx;
			activeD <= (tx < H_ACTIVE) && (ty < V_ACTIVE);
		end
	end

	// one flap decision per frame from a height model of the bird
	always @(posedge clk25M) begin
		logic flap;
		flap = 1'b0;
		if (rst && boundary) begin
			frameNo <= frameNo + 1;
			if (pressed) framesSincePress <= framesSincePress + 1;
			if (frameNo == 2) begin
				flap = 1'b1;
			end else if (pressed && !stopFlap) begin
				if (modelY >= 48) flap = 1'b1;
				else if (modelY > 36) flap = ($urandom % 3) == 0;
			end
			if (flap) begin
				btnUp <= 1'b0;
				pressed <= 1'b1;
				modelY <= (modelY > FLAP_RISE) ? modelY - FLAP_RISE : 0;
			end else if (pressed) begin
				modelY <= modelY + GRAVITY_STEP;
			end
			if (scored) stopFlap <= 1'b1;
		end else if (rst && tx == 8) begin
			btnUp <= 1'b1;
		end
	end

	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			lastScore <= 0;
			lastValid <= 1'b0;
			scored <= 1'b0;
			birdSeen <= 1'b0;
			crashSeen <= 1'b0;
			crashScore <= 0;
			blankLast <= 1'b0;
			runLen <= 0;
			runClean <= 1'b0;
			flashChecks <= 0;
		end else begin
			lastValid <= valid;
			if (valid) lastScore <= curScore;
			if (valid && curScore >= 1) scored <= 1'b1;
			if (pressed && activeD && colD == BIRD_X && rgb == BIRD_COLOR) birdSeen <= 1'b1;
			if (activeD && rgb == CRASH_COLOR && !crashSeen) begin
				crashSeen <= 1'b1;
				crashScore <= lastScore;
			end
			blankLast <= blank;
			if (blank != blankLast) begin
				runLen <= 0;
				runClean <= boundary;
				if (crashSeen && runClean) flashChecks <= flashChecks + 1;
			end else if (boundary) begin
				runLen <= runLen + 1;
			end
		end
	end

	always @(posedge clk25M) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			failRun("timeout: crash flashing never completed");
		end else if (UUT.props.failCount != 0) begin
			failRun("a bound timing or phase property failed");
		end
	end

	blankOutside: assert property (@(posedge clk25M) disable iff (!rst)
		!activeD |-> rgb == 12'h000)
		else failRun($sformatf("MISMATCH rgb got %h expected %h", rgb, 12'h000));
	idleNoPipe: assert property (@(posedge clk25M) disable iff (!rst)
		(!pressed && activeD) |-> rgb != PIPE_COLOR)
		else failRun($sformatf("MISMATCH rgb got %h, pipe shown before a press", rgb));
	idleSegs: assert property (@(posedge clk25M) disable iff (!rst)
		!pressed |-> (seg0 == 7'h40 && seg1 == 7'h40))
		else failRun($sformatf("MISMATCH seg1/seg0 got %h/%h expected 40/40", seg1, seg0));
	birdShown: assert property (@(posedge clk25M) disable iff (!rst)
		(pressed && framesSincePress >= 2) |-> birdSeen)
		else failRun("bird colour never appeared at column BIRD_X after the press");
	scoreStep: assert property (@(posedge clk25M) disable iff (!rst)
		(valid && lastValid && curScore != lastScore) |->
		(boundary && !crashSeen && curScore == lastScore + 1))
		else failRun($sformatf("MISMATCH score got %h expected %h", curScore, lastScore + 1));
	crashScoreHeld: assert property (@(posedge clk25M) disable iff (!rst)
		crashSeen |-> (blank || (valid && curScore == crashScore)))
		else failRun($sformatf("MISMATCH seg1/seg0 got %h/%h expected blank or score %h",
			seg1, seg0, crashScore));
	crashFill: assert property (@(posedge clk25M) disable iff (!rst)
		(crashSeen && activeD) |-> rgb == CRASH_COLOR)
		else failRun($sformatf("MISMATCH rgb got %h expected %h", rgb, CRASH_COLOR));
	flashLength: assert property (@(posedge clk25M) disable iff (!rst)
		(crashSeen && blank != blankLast && runClean) |->
		(boundary && runLen == FLASH_FRAMES - 1))
		else failRun("crash flash state did not last exactly FLASH_FRAMES frames");

endmodule

// ==== tests/flappyTop_props.sv ====
`timescale 1ns/1ps

module flappyTopProps
	import flapPkg::*;
#(
	parameter int H_ACTIVE = DEF_H_ACTIVE
) (
	input logic clk25M,
	input logic rst,
	input logic hsync,
	input logic vsync,
	input gamePhase_t phase
);

	localparam int H_TOTAL = H_ACTIVE + 160;

	int failCount = 0;
	int hLow;
	int vLow;
	int hPeriod;
	logic hsLast;
	logic vsLast;
	logic hFellOnce;

	always_ff @(posedge clk25M or negedge rst) begin
		if (!rst) begin
			hLow <= 0;
			vLow <= 0;
			hPeriod <= 0;
			hsLast <= 1'b1;
			vsLast <= 1'b1;
			hFellOnce <= 1'b0;
		end else begin
			hsLast <= hsync;
			vsLast <= vsync;
			hLow <= hsync ? 0 : hLow + 1;
			vLow <= vsync ? 0 : vLow + 1;
			if (hsLast && !hsync) begin
				hPeriod <= 1;
				hFellOnce <= 1'b1;
			end else begin
				hPeriod <= hPeriod + 1;
			end
		end
	end

	hsyncWidth: assert property (@(posedge clk25M) disable iff (!rst)
		(hsync && !hsLast) |-> hLow == H_SYNC)
		else begin failCount++; $error("hsync low width wrong"); end
	hsyncPeriod: assert property (@(posedge clk25M) disable iff (!rst)
		(hsLast && !hsync && hFellOnce) |-> hPeriod == H_TOTAL)
		else begin failCount++; $error("hsync period wrong"); end
	vsyncWidth: assert property (@(posedge clk25M) disable iff (!rst)
		(vsync && !vsLast) |-> vLow == V_SYNC * H_TOTAL)
		else begin failCount++; $error("vsync low width wrong"); end
	// crash is final and idle never jumps straight to crash
	crashHeld: assert property (@(posedge clk25M) disable iff (!rst)
		$past(phase) == phCrashed |-> phase == phCrashed)
		else begin failCount++; $error("phase left crash state"); end
	idleExit: assert property (@(posedge clk25M) disable iff (!rst)
		$past(phase) == phIdle |-> phase != phCrashed)
		else begin failCount++; $error("phase went from idle to crash"); end

endmodule

bind flappyTop flappyTopProps #(.H_ACTIVE(H_ACTIVE)) props (
	.clk25M(clk25M), .rst(rst), .hsync(hsync), .vsync(vsync), .phase(phase)
);
